// File: all.f
logic/cpri_pack_pkg.sv
logic/prb_frame_collector.sv
logic/frame_pingpong_buffer.sv
logic/cpri_frame_packer.sv
logic/cpri_pack_top.sv
test/cpri_pack_tb.sv

// File: Makefile
# Verilator build and run of the CPRI packer testbench

VERILATOR ?= verilator
TOP       ?= cpri_pack_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Simulation FAILED" $(LOG); then \
		echo "test failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: test/cpri_pack_tb.sv
`default_nettype none

module cpri_pack_tb;

    // 6 frames of 96 input beats and about 98 output cycles, plus reset and idle slack
    localparam int TIMEOUT_CYCLES = 3000;
    localparam int N              = cpri_pack_pkg::FRAME_WORDS;

    logic                               clk;
    logic                               rst;
    logic                               i_vld;
    logic                               i_sop;
    logic                               i_eop;
    cpri_pack_pkg::prb_meta_t           i_meta;
    cpri_pack_pkg::sample_beat_t        i_samples;
    cpri_pack_pkg::shift_beat_t         i_shift;
    wire                                o_cpri_wen;
    wire cpri_pack_pkg::cpri_addr_t     o_cpri_waddr;
    wire cpri_pack_pkg::cpri_word_t     o_cpri_wdata;
    wire                                o_cpri_wlast;

    int errors = 0;
    int checks = 0;
    int cycle_cnt = 0;

    // writes seen on the CPRI side
    cpri_pack_pkg::cpri_addr_t   got_addr [$];
    cpri_pack_pkg::cpri_word_t   got_data [$];
    logic                        got_last [$];
    int                          got_cyc [$];

    // reference writes, in output order
    cpri_pack_pkg::cpri_addr_t   exp_addr [$];
    cpri_pack_pkg::cpri_word_t   exp_data [$];

    // stimulus of the frame being driven
    cpri_pack_pkg::sample_beat_t frm_samples [N];
    cpri_pack_pkg::prb_meta_t    frm_meta [cpri_pack_pkg::PRBS_PER_FRAME];
    cpri_pack_pkg::shift_beat_t  frm_shift [cpri_pack_pkg::PRBS_PER_FRAME];

    cpri_pack_top cpri_pack_top_i (
        .clk          (clk),
        .rst          (rst),
        .i_vld        (i_vld),
        .i_sop        (i_sop),
        .i_eop        (i_eop),
        .i_meta       (i_meta),
        .i_samples    (i_samples),
        .i_shift      (i_shift),
        .o_cpri_wen   (o_cpri_wen),
        .o_cpri_waddr (o_cpri_waddr),
        .o_cpri_wdata (o_cpri_wdata),
        .o_cpri_wlast (o_cpri_wlast)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("timeout after %0d cycles, the DUT never finished its writes", cycle_cnt);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // outputs are registered, so the falling edge sees them settled
    always @(negedge clk)
    begin
        if (!rst && o_cpri_wen === 1'b1)
        begin
            got_addr.push_back(o_cpri_waddr);
            got_data.push_back(o_cpri_wdata);
            got_last.push_back(o_cpri_wlast);
            got_cyc.push_back(cycle_cnt);
        end
    end

    // ------------------------------
    // helpers
    // ------------------------------
    task automatic idle_inputs();
        i_vld     = 1'b0;
        i_sop     = 1'b0;
        i_eop     = 1'b0;
        i_meta    = '0;
        i_samples = '0;
        i_shift   = '0;
    endtask

    task automatic report_mismatch(input string name, input string what,
                                   input logic [63:0] expv, input logic [63:0] actv);
        errors++;
        $display("** Error [%s] %s: expected 0x%0h, actual 0x%0h", name, what, expv, actv);
    endtask

    task automatic clear_capture();
        got_addr.delete();
        got_data.delete();
        got_last.delete();
        got_cyc.delete();
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic make_frame();
        logic [31:0] r32;
        logic [63:0] r64;
        for (int b = 0; b < N; b++)
        begin
            for (int a = 0; a < cpri_pack_pkg::NUM_ANT; a++)
            begin
                r32 = $urandom;
                frm_samples[b][a] = r32[13:0];
            end
        end
        for (int n = 0; n < cpri_pack_pkg::PRBS_PER_FRAME; n++)
        begin
            r64 = {$urandom, $urandom};
            frm_meta[n] = r64[32:0];
            r32 = $urandom;
            frm_shift[n] = r32[15:0];
        end
    endtask

    // reference writes of one frame from the output rule
    task automatic add_expected();
        logic [8*cpri_pack_pkg::SAMPLE_W-1:0] run;
        cpri_pack_pkg::cpri_word_t            head;
        cpri_pack_pkg::cpri_word_t            word;
        cpri_pack_pkg::shift_word_t           sh [cpri_pack_pkg::NUM_ANT];
        int                                   g;
        int                                   p;
        head = {24'h0, frm_meta[0].ch_type, frm_meta[0].prb_idx[7:0],
                frm_meta[4].prb_idx[7:0], frm_meta[0].cell_idx, frm_meta[0].slot_idx,
                frm_meta[0].sym_idx, frm_meta[0].info[7:4], frm_meta[4].info[7:4]};
        for (int a = 0; a < cpri_pack_pkg::NUM_ANT; a++)
        begin
            for (int n = 0; n < cpri_pack_pkg::PRBS_PER_FRAME; n++)
                sh[a][n] = frm_shift[n][a];
        end
        for (int r = 0; r < N; r++)
        begin
            g = r / 8;
            p = r % 8;
            word = '0;
            if (p == 0)
            begin
                if (g < 7)
                    exp_addr.push_back(cpri_pack_pkg::cpri_addr_t'(g));
                else
                    exp_addr.push_back(cpri_pack_pkg::cpri_addr_t'(91 + g - 7));
                if (g == 3)
                    word = head;
                else if (g == 5)
                    word = {sh[1], sh[0]};
                else if (g == 6)
                    word = {sh[3], sh[2]};
            end
            else
            begin
                exp_addr.push_back(cpri_pack_pkg::cpri_addr_t'(7 + 7 * g + p - 1));
                for (int a = 0; a < cpri_pack_pkg::NUM_ANT; a++)
                begin
                    // group samples laid end to end, sample 0 lowest
                    for (int s = 0; s < 8; s++)
                        run[14*s +: 14] = frm_samples[8*g + s][a];
                    word[16*a +: 16] = run[16*(p-1) +: 16];
                end
            end
            exp_data.push_back(word);
        end
    endtask

    task automatic drive_frame();
        logic [63:0] noise;
        make_frame();
        add_expected();
        for (int b = 0; b < N; b++)
        begin
            @(negedge clk);
            noise     = {$urandom, $urandom};
            i_vld     = 1'b1;
            i_sop     = (b % 12 == 0);
            i_eop     = (b % 12 == 11);
            // metadata and shift only matter on sop beats
            i_meta    = (b % 12 == 0) ? frm_meta[b / 12] : noise[32:0];
            i_samples = frm_samples[b];
            i_shift   = (b % 12 == 0) ? frm_shift[b / 12] : noise[63:48];
        end
    endtask

    task automatic end_frames();
        @(negedge clk);
        idle_inputs();
    endtask

    // a few quiet cycles after the count, so extra writes still get caught
    task automatic wait_writes(input int n);
        while (got_addr.size() < n)
            @(posedge clk);
        repeat (4) @(negedge clk);
    endtask

    // ------------------------------
    // checkers
    // ------------------------------
    task automatic check_burst(input string name);
        bit seen [N];
        int idx;
        int addr;
        checks++;
        if (got_addr.size() != exp_addr.size())
            report_mismatch(name, "write count", 64'(exp_addr.size()), 64'(got_addr.size()));
        else
        begin
            for (int f = 0; f < exp_addr.size() / N; f++)
            begin
                for (int a = 0; a < N; a++)
                    seen[a] = 1'b0;
                for (int i = 0; i < N; i++)
                begin
                    idx  = f * N + i;
                    addr = int'(got_addr[idx]);
                    checks++;
                    if (got_addr[idx] != exp_addr[idx])
                        report_mismatch(name, $sformatf("address of write %0d", idx),
                                        64'(exp_addr[idx]), 64'(got_addr[idx]));
                    if (got_last[idx] !== (i == N - 1))
                        report_mismatch(name, $sformatf("wlast of write %0d", idx),
                                        64'(i == N - 1), 64'(got_last[idx]));
                    if (i > 0 && got_cyc[idx] != got_cyc[idx-1] + 1)
                    begin
                        errors++;
                        $display("[%s] frame %0d has a gap in its writes before write %0d",
                                 name, f, i);
                    end
                    if (addr < N)
                    begin
                        if (seen[addr])
                        begin
                            errors++;
                            $display("[%s] frame %0d wrote address %0d twice", name, f, addr);
                        end
                        seen[addr] = 1'b1;
                    end
                end
                for (int a = 0; a < N; a++)
                begin
                    if (!seen[a])
                    begin
                        errors++;
                        $display("[%s] frame %0d never wrote address %0d", name, f, a);
                    end
                end
            end
        end
    endtask

    task automatic check_data(input string name, input bit want_slots);
        bit is_slot;
        for (int i = 0; i < got_data.size() && i < exp_data.size(); i++)
        begin
            is_slot = (i % 8 == 0);
            if (is_slot == want_slots)
            begin
                checks++;
                if (got_data[i] !== exp_data[i])
                    report_mismatch(name, $sformatf("word at address %0d", exp_addr[i]),
                                    exp_data[i], got_data[i]);
            end
        end
    endtask

    // ------------------------------
    // directed tests
    // ------------------------------
    task automatic test_reset_idle();
        // first rising edge loads the reset values
        @(posedge clk);
        repeat (8)
        begin
            @(negedge clk);
            checks++;
            if ({o_cpri_wen, o_cpri_wlast} !== 2'b00)
                report_mismatch("reset_idle", "wen and wlast in reset", 64'(0),
                                64'({o_cpri_wen, o_cpri_wlast}));
        end
        rst = 1'b0;
        repeat (20)
        begin
            @(negedge clk);
            checks++;
            if ({o_cpri_wen, o_cpri_wlast} !== 2'b00)
                report_mismatch("reset_idle", "wen and wlast while idle", 64'(0),
                                64'({o_cpri_wen, o_cpri_wlast}));
        end
    endtask

    task automatic test_single_frame();
        clear_capture();
        drive_frame();
        end_frames();
        wait_writes(N);
        check_burst("single_frame");
    endtask

    task automatic test_data_repack();
        clear_capture();
        drive_frame();
        end_frames();
        wait_writes(N);
        check_data("data_repack", 1'b0);
    endtask

    task automatic test_slot_words();
        clear_capture();
        drive_frame();
        end_frames();
        wait_writes(N);
        check_data("slot_words", 1'b1);
    endtask

    // both banks in flight at once
    task automatic test_back_to_back();
        clear_capture();
        repeat (3) drive_frame();
        end_frames();
        wait_writes(3 * N);
        check_burst("back_to_back");
        check_data("back_to_back", 1'b0);
        check_data("back_to_back", 1'b1);
    endtask

    initial
    begin
        void'($urandom(70609));
        rst = 1'b1;
        idle_inputs();
        test_reset_idle();
        test_single_frame();
        test_data_repack();
        test_slot_words();
        test_back_to_back();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/cpri_pack_top.sv
`default_nettype none

module cpri_pack_top (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                i_vld,
    input  wire                                i_sop,
    input  wire                                i_eop,
    input  wire cpri_pack_pkg::prb_meta_t      i_meta,
    input  wire cpri_pack_pkg::sample_beat_t   i_samples,
    input  wire cpri_pack_pkg::shift_beat_t    i_shift,
    output wire                                o_cpri_wen,
    output wire cpri_pack_pkg::cpri_addr_t     o_cpri_waddr,
    output wire cpri_pack_pkg::cpri_word_t     o_cpri_wdata,
    output wire                                o_cpri_wlast
);

    // collector to buffer
    wire                              wr_en;
    wire cpri_pack_pkg::word_idx_t    wr_idx;
    wire cpri_pack_pkg::sample_beat_t wr_beat;
    wire                              wr_last;
    wire cpri_pack_pkg::frame_info_t  wr_info;

    // buffer and packer
    wire                              rd_ready;
    wire cpri_pack_pkg::sample_beat_t rd_beat;
    wire cpri_pack_pkg::frame_info_t  rd_info;
    wire                              rd_en;
    wire cpri_pack_pkg::word_idx_t    rd_idx;
    wire                              rd_last;

    prb_frame_collector prb_frame_collector_i (
        .clk        (clk),
        .rst        (rst),
        .i_vld      (i_vld),
        .i_sop      (i_sop),
        .i_eop      (i_eop),
        .i_meta     (i_meta),
        .i_samples  (i_samples),
        .i_shift    (i_shift),
        .o_wr_en    (wr_en),
        .o_wr_idx   (wr_idx),
        .o_wr_beat  (wr_beat),
        .o_wr_last  (wr_last),
        .o_wr_info  (wr_info)
    );

    frame_pingpong_buffer frame_pingpong_buffer_i (
        .clk        (clk),
        .rst        (rst),
        .i_wr_en    (wr_en),
        .i_wr_idx   (wr_idx),
        .i_wr_beat  (wr_beat),
        .i_wr_last  (wr_last),
        .i_wr_info  (wr_info),
        .i_rd_en    (rd_en),
        .i_rd_idx   (rd_idx),
        .i_rd_last  (rd_last),
        .o_rd_ready (rd_ready),
        .o_rd_beat  (rd_beat),
        .o_rd_info  (rd_info)
    );

    cpri_frame_packer cpri_frame_packer_i (
        .clk          (clk),
        .rst          (rst),
        .i_rd_ready   (rd_ready),
        .i_rd_beat    (rd_beat),
        .i_rd_info    (rd_info),
        .o_rd_en      (rd_en),
        .o_rd_idx     (rd_idx),
        .o_rd_last    (rd_last),
        .o_cpri_wen   (o_cpri_wen),
        .o_cpri_waddr (o_cpri_waddr),
        .o_cpri_wdata (o_cpri_wdata),
        .o_cpri_wlast (o_cpri_wlast)
    );

endmodule

`default_nettype wire

// File: logic/cpri_frame_packer.sv
`default_nettype none

module cpri_frame_packer (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                i_rd_ready,
    input  wire cpri_pack_pkg::sample_beat_t   i_rd_beat,
    input  wire cpri_pack_pkg::frame_info_t    i_rd_info,
    output logic                               o_rd_en,
    output cpri_pack_pkg::word_idx_t           o_rd_idx,
    output logic                               o_rd_last,
    output logic                               o_cpri_wen,
    output cpri_pack_pkg::cpri_addr_t          o_cpri_waddr,
    output cpri_pack_pkg::cpri_word_t          o_cpri_wdata,
    output logic                               o_cpri_wlast
);

    cpri_pack_pkg::packer_state_t state_q;
    cpri_pack_pkg::word_idx_t     rd_idx_q;
    logic                         vld_d1;
    logic                         last_d1;
    logic [3:0]                   grp_d1;
    logic [2:0]                   pos_d1;
    cpri_pack_pkg::sample_beat_t  prev_q;
    cpri_pack_pkg::cpri_addr_t    data_addr_q;
    cpri_pack_pkg::cpri_word_t    packed_word;
    cpri_pack_pkg::cpri_word_t    slot_word;
    cpri_pack_pkg::cpri_addr_t    slot_addr;

    // word k of a group takes the tail of sample k-1 and the head of sample k
    function automatic cpri_pack_pkg::packed_t pack16(
        input cpri_pack_pkg::sample_t prev,
        input cpri_pack_pkg::sample_t cur,
        input logic [2:0]             pos
    );
        logic [2*cpri_pack_pkg::SAMPLE_W-1:0] pair;
        pair = {cur, prev} >> {pos - 3'd1, 1'b0};
        return pair[cpri_pack_pkg::PACKED_W-1:0];
    endfunction

    // ------------------------------
    // read sequencer
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q  <= cpri_pack_pkg::IDLE;
            rd_idx_q <= '0;
        end
        else
        begin
            case (state_q)
                cpri_pack_pkg::IDLE:
                begin
                    rd_idx_q <= '0;
                    if (i_rd_ready)
                        state_q <= cpri_pack_pkg::READ;
                end
                cpri_pack_pkg::READ:
                begin
                    rd_idx_q <= rd_idx_q + 1'b1;
                    if (o_rd_last)
                        state_q <= cpri_pack_pkg::IDLE;
                end
            endcase
        end
    end

    assign o_rd_en   = (state_q == cpri_pack_pkg::READ);
    assign o_rd_idx  = rd_idx_q;
    assign o_rd_last = o_rd_en &&
        (rd_idx_q == cpri_pack_pkg::word_idx_t'(cpri_pack_pkg::FRAME_WORDS - 1));

    // ------------------------------
    // stage 1, read data returns
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            vld_d1  <= 1'b0;
            last_d1 <= 1'b0;
        end
        else
        begin
            vld_d1  <= o_rd_en;
            last_d1 <= o_rd_last;
        end
    end

    always_ff @(posedge clk)
    begin
        if (o_rd_en)
        begin
            grp_d1 <= 4'(rd_idx_q / cpri_pack_pkg::GROUP_LEN);
            pos_d1 <= 3'(rd_idx_q % cpri_pack_pkg::GROUP_LEN);
        end
        if (vld_d1)
            prev_q <= i_rd_beat;
    end

    // 14 to 16 bit repack, antenna 0 lowest
    always_comb
    begin
        for (int a = 0; a < cpri_pack_pkg::NUM_ANT; a++)
        begin
            packed_word[a*cpri_pack_pkg::PACKED_W +: cpri_pack_pkg::PACKED_W] =
                pack16(prev_q[a], i_rd_beat[a], pos_d1);
        end
    end

    // slot words at group position 0
    always_comb
    begin
        case (grp_d1)
            4'(cpri_pack_pkg::HEAD_SLOT):
                slot_word = i_rd_info.head;
            4'(cpri_pack_pkg::SHIFT_LO_SLOT):
                slot_word = {i_rd_info.ant_shift[1], i_rd_info.ant_shift[0]};
            4'(cpri_pack_pkg::SHIFT_HI_SLOT):
                slot_word = {i_rd_info.ant_shift[3], i_rd_info.ant_shift[2]};
            4'(cpri_pack_pkg::ZERO_SLOT):
                slot_word = '0;
            default:
                slot_word = '0;
        endcase
    end

    // groups 7..11 put their slot above the data area
    assign slot_addr = (grp_d1 < cpri_pack_pkg::DATA_ADDR_FIRST) ?
        cpri_pack_pkg::cpri_addr_t'(grp_d1) :
        cpri_pack_pkg::cpri_addr_t'(cpri_pack_pkg::HIGH_SLOT_BASE + int'(grp_d1)
            - cpri_pack_pkg::DATA_ADDR_FIRST);

    // ------------------------------
    // stage 2, CPRI write
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            o_cpri_wen   <= 1'b0;
            o_cpri_wlast <= 1'b0;
            data_addr_q  <= cpri_pack_pkg::cpri_addr_t'(cpri_pack_pkg::DATA_ADDR_FIRST);
        end
        else
        begin
            o_cpri_wen   <= vld_d1;
            o_cpri_wlast <= last_d1;
            if (vld_d1 && (pos_d1 != '0))
            begin
                if (data_addr_q == cpri_pack_pkg::cpri_addr_t'(cpri_pack_pkg::DATA_ADDR_LAST))
                    data_addr_q <= cpri_pack_pkg::cpri_addr_t'(cpri_pack_pkg::DATA_ADDR_FIRST);
                else
                    data_addr_q <= data_addr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (vld_d1)
        begin
            if (pos_d1 == '0)
            begin
                o_cpri_waddr <= slot_addr;
                o_cpri_wdata <= slot_word;
            end
            else
            begin
                o_cpri_waddr <= data_addr_q;
                o_cpri_wdata <= packed_word;
            end
        end
    end

    // the frame closes on the top data word
    assert property (@(posedge clk) disable iff (rst)
        o_cpri_wlast |-> o_cpri_wen &&
            (o_cpri_waddr == cpri_pack_pkg::cpri_addr_t'(cpri_pack_pkg::DATA_ADDR_LAST)))
        else $error("wlast outside the last data write");

    // a write burst is one whole frame
    assert property (@(posedge clk) disable iff (rst)
        $rose(o_cpri_wen) |-> ##(cpri_pack_pkg::FRAME_WORDS - 1) o_cpri_wlast)
        else $error("write burst length differs from a frame");

endmodule

`default_nettype wire

// File: logic/frame_pingpong_buffer.sv
`default_nettype none

module frame_pingpong_buffer (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                i_wr_en,
    input  wire cpri_pack_pkg::word_idx_t      i_wr_idx,
    input  wire cpri_pack_pkg::sample_beat_t   i_wr_beat,
    input  wire                                i_wr_last,
    input  wire cpri_pack_pkg::frame_info_t    i_wr_info,
    input  wire                                i_rd_en,
    input  wire cpri_pack_pkg::word_idx_t      i_rd_idx,
    input  wire                                i_rd_last,
    output logic                               o_rd_ready,
    output cpri_pack_pkg::sample_beat_t        o_rd_beat,
    output cpri_pack_pkg::frame_info_t         o_rd_info
);

    cpri_pack_pkg::sample_beat_t mem [2][cpri_pack_pkg::FRAME_WORDS];
    cpri_pack_pkg::frame_info_t  info_q [2];
    cpri_pack_pkg::bank_state_t  state_q [2];
    logic                        wr_bank;
    logic                        rd_bank;

    // ------------------------------
    // sample store, one cycle read
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (i_wr_en)
            mem[wr_bank][i_wr_idx] <= i_wr_beat;
        if (i_rd_en)
            o_rd_beat <= mem[rd_bank][i_rd_idx];
    end

    // frame info lands with the last beat
    always_ff @(posedge clk)
    begin
        if (i_wr_last)
            info_q[wr_bank] <= i_wr_info;
    end

    // ------------------------------
    // bank pointers and state
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_bank <= 1'b0;
            rd_bank <= 1'b0;
            for (int b = 0; b < 2; b++)
            begin
                state_q[b] <= cpri_pack_pkg::EMPTY;
            end
        end
        else
        begin
            if (i_wr_last)
            begin
                state_q[wr_bank] <= cpri_pack_pkg::FULL;
                wr_bank          <= ~wr_bank;
            end
            if (i_rd_last)
            begin
                state_q[rd_bank] <= cpri_pack_pkg::EMPTY;
                rd_bank          <= ~rd_bank;
            end
            else if (i_rd_en)
                state_q[rd_bank] <= cpri_pack_pkg::READING;
        end
    end

    assign o_rd_ready = (state_q[rd_bank] == cpri_pack_pkg::FULL);
    assign o_rd_info  = info_q[rd_bank];

    // overrun check, a bank drained by this cycle's last read counts as free
    assert property (@(posedge clk) disable iff (rst)
        i_wr_en |-> (state_q[wr_bank] == cpri_pack_pkg::EMPTY) ||
            (i_rd_last && (rd_bank == wr_bank)))
        else $error("write into a bank that still holds a frame");

endmodule

`default_nettype wire

// File: logic/prb_frame_collector.sv
`default_nettype none

module prb_frame_collector (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                i_vld,
    input  wire                                i_sop,
    input  wire                                i_eop,
    input  wire cpri_pack_pkg::prb_meta_t      i_meta,
    input  wire cpri_pack_pkg::sample_beat_t   i_samples,
    input  wire cpri_pack_pkg::shift_beat_t    i_shift,
    output logic                               o_wr_en,
    output cpri_pack_pkg::word_idx_t           o_wr_idx,
    output cpri_pack_pkg::sample_beat_t        o_wr_beat,
    output logic                               o_wr_last,
    output cpri_pack_pkg::frame_info_t         o_wr_info
);

    cpri_pack_pkg::word_idx_t   beat_cnt;
    cpri_pack_pkg::prb_idx_t    prb_cnt;
    cpri_pack_pkg::frame_info_t info_q;
    cpri_pack_pkg::frame_info_t info_next;
    logic                       frame_end;

    assign frame_end = i_vld &&
        (beat_cnt == cpri_pack_pkg::word_idx_t'(cpri_pack_pkg::FRAME_WORDS - 1));

    // ------------------------------
    // beat and PRB counters
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            beat_cnt <= '0;
            prb_cnt  <= '0;
        end
        else if (i_vld)
        begin
            if (frame_end)
                beat_cnt <= '0;
            else
                beat_cnt <= beat_cnt + 1'b1;
            // PRB index wraps with the frame, 8 eops per frame
            if (i_eop)
                prb_cnt <= prb_cnt + 1'b1;
        end
    end

    // ------------------------------
    // header and shift capture
    // ------------------------------
    always_comb
    begin
        info_next = info_q;
        if (i_vld && i_sop)
        begin
            // common fields and first half of the header from PRB 0
            if (prb_cnt == '0)
            begin
                info_next.head[63:40] = '0;
                info_next.head[39:36] = i_meta.ch_type;
                info_next.head[35:28] = i_meta.prb_idx[7:0];
                info_next.head[19:8]  = {i_meta.cell_idx, i_meta.slot_idx, i_meta.sym_idx};
                info_next.head[7:4]   = i_meta.info[7:4];
            end
            // second half from PRB 4
            if (prb_cnt == cpri_pack_pkg::prb_idx_t'(cpri_pack_pkg::PRBS_PER_FRAME / 2))
            begin
                info_next.head[27:20] = i_meta.prb_idx[7:0];
                info_next.head[3:0]   = i_meta.info[7:4];
            end
            for (int a = 0; a < cpri_pack_pkg::NUM_ANT; a++)
            begin
                info_next.ant_shift[a][prb_cnt] = i_shift[a];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (i_vld)
            info_q <= info_next;
    end

    // write side of the buffer follows the input beat directly
    assign o_wr_en   = i_vld;
    assign o_wr_idx  = beat_cnt;
    assign o_wr_beat = i_samples;
    assign o_wr_last = frame_end;
    assign o_wr_info = info_next;

    // ------------------------------
    // checks
    // ------------------------------
    // eop is a qualifier of a valid beat
    assert property (@(posedge clk) disable iff (rst) i_eop |-> i_vld)
        else $error("eop seen without vld");

    // beat count and eop count must agree at every frame end
    assert property (@(posedge clk) disable iff (rst)
        frame_end |-> i_eop &&
            (prb_cnt == cpri_pack_pkg::prb_idx_t'(cpri_pack_pkg::PRBS_PER_FRAME - 1)))
        else $error("frame end not aligned with the eighth eop");

endmodule

`default_nettype wire

// File: logic/cpri_pack_pkg.sv
`default_nettype none

package cpri_pack_pkg;

    // ------------------------------
    // frame geometry
    // ------------------------------
    localparam int NUM_ANT        = 4;
    localparam int SAMPLE_W       = 14;
    localparam int PACKED_W       = 16;
    localparam int BEATS_PER_PRB  = 12;
    localparam int PRBS_PER_FRAME = 8;
    localparam int FRAME_WORDS    = BEATS_PER_PRB * PRBS_PER_FRAME;
    localparam int GROUP_LEN      = 8;
    localparam int NUM_GROUPS     = FRAME_WORDS / GROUP_LEN;

    // ------------------------------
    // output address map
    // ------------------------------
    localparam int DATA_ADDR_FIRST = 7;
    localparam int DATA_ADDR_LAST  = 90;
    localparam int HIGH_SLOT_BASE  = 91;
    localparam int HEAD_SLOT       = 3;
    localparam int ZERO_SLOT       = 4;
    localparam int SHIFT_LO_SLOT   = 5;
    localparam int SHIFT_HI_SLOT   = 6;

    typedef logic [SAMPLE_W-1:0] sample_t;
    typedef logic [PACKED_W-1:0] packed_t;
    typedef logic [63:0]         cpri_word_t;
    typedef logic [6:0]          cpri_addr_t;
    typedef logic [6:0]          word_idx_t;
    typedef logic [2:0]          prb_idx_t;
    typedef logic [3:0]          shift_t;

    // nibble n belongs to PRB n of the frame
    typedef shift_t [PRBS_PER_FRAME-1:0] shift_word_t;

    typedef struct packed {
        logic [3:0] ch_type;
        logic       cell_idx;
        logic [6:0] slot_idx;
        logic [3:0] sym_idx;
        logic [8:0] prb_idx;
        logic [7:0] info;
    } prb_meta_t;

    // antenna 0 in the low bits
    typedef sample_t [NUM_ANT-1:0] sample_beat_t;
    typedef shift_t [NUM_ANT-1:0]  shift_beat_t;

    typedef struct packed {
        cpri_word_t                head;
        shift_word_t [NUM_ANT-1:0] ant_shift;
    } frame_info_t;

    typedef enum logic [1:0] {
        EMPTY,
        FULL,
        READING
    } bank_state_t;

    typedef enum logic {
        IDLE,
        READ
    } packer_state_t;

endpackage

`default_nettype wire
